// File: Makefile
TOP = mipsDecodeTb

.PHONY: all lint clean

all:
	verilator --binary --assert --timescale 1ns/100ps -f mipsDecode.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f mipsDecode.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir

// File: dv/mipsDecodeTb.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module mipsDecodeTb
    import mipsPkg::*;
;

    localparam int pipeLatency   = 3;
    localparam int directedCount = 39;
    localparam int randomCount   = 200;
    // Every random instruction may be followed by one bubble
    localparam int totalSlots    = directedCount + 2 * randomCount;
    localparam int watchdogNs    = (totalSlots + 3 + 2) * 20 * 2;
    localparam logic [5:0] aluFuncts [6] = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h2a};

    typedef struct packed {
        logic [31:0] issue;
        logic [1:0]  regWrite;
        logic [4:0]  destReg;
        logic [2:0]  wbSrc;
        logic        memRead;
        logic        memWrite;
        logic        hiWrite;
        logic        loWrite;
        logic        jump;
        logic        jumpReg;
        logic        delaySlot;
        logic        branch;
        logic [31:0] target;
    } expectT;

    logic                      clk;
    logic                      reset;
    logic                      instrValid;
    logic [`MIPS_WORD-1:0]     instr;
    logic [`MIPS_WORD-1:0]     pc;
    logic                      outValid;
    logic [1:0]                regWrite;
    logic [`MIPS_REG_BITS-1:0] destReg;
    wbSrcT                     wbSrc;
    logic                      memRead;
    logic                      memWrite;
    logic                      hiWrite;
    logic                      loWrite;
    logic                      jump;
    logic                      jumpReg;
    logic                      delaySlot;
    logic                      branch;
    logic [`MIPS_WORD-1:0]     target;

    expectT     expQ[$];
    logic [5:0] opPool[$];
    logic [5:0] fnPool[$];
    int         seed = 28376;
    int         cycleCount = 0;
    int         checkCount = 0;
    int         errorCount = 0;
    int         testChecks;
    int         testErrors;

    mipsDecodePipe i_dut (.*);

    always #10 clk = ~clk;

    // Expected outputs straight from the decode rules
    function automatic expectT predictDecode(input logic [31:0] word, input logic [31:0] pcVal);
        expectT      e;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rt;
        logic [1:0]  dst;
        logic [31:0] pc4;
        logic [31:0] offset;
        e      = '0;
        op     = word[31:26];
        fn     = word[5:0];
        rt     = word[20:16];
        dst    = 2'd0;
        pc4    = pcVal + 32'd4;
        offset = {{14{word[15]}}, word[15:0], 2'b00};
        if (op == opRtype)
        begin
            dst        = 2'd1;
            e.regWrite = 2'b11;
            case (fn)
                fnJr:
                begin
                    e.regWrite  = 2'b00;
                    e.jumpReg   = 1'b1;
                    e.delaySlot = 1'b1;
                end
                fnJalr:
                begin
                    e.jumpReg   = 1'b1;
                    e.delaySlot = 1'b1;
                    e.wbSrc     = wbPcPlus8;
                end
                fnMfhi: e.wbSrc = wbHi;
                fnMflo: e.wbSrc = wbLo;
                fnMthi:
                begin
                    e.regWrite = 2'b00;
                    e.hiWrite  = 1'b1;
                end
                fnMtlo:
                begin
                    e.regWrite = 2'b00;
                    e.loWrite  = 1'b1;
                end
                fnMult, fnMultu, fnDiv, fnDivu:
                begin
                    e.regWrite = 2'b00;
                    e.hiWrite  = 1'b1;
                    e.loWrite  = 1'b1;
                end
                default: e.wbSrc = wbAlu;
            endcase
        end
        else if (op inside {opLb, opLh, opLwl, opLw, opLbu, opLhu, opLwr})
        begin
            e.memRead  = 1'b1;
            e.wbSrc    = wbMem;
            e.regWrite = (op == opLwl) ? 2'b01 : ((op == opLwr) ? 2'b10 : 2'b11);
        end
        else if (op inside {opSb, opSh, opSw})
            e.memWrite = 1'b1;
        else if (op == opJ || op == opJal)
        begin
            e.jump      = 1'b1;
            e.delaySlot = 1'b1;
            if (op == opJal)
            begin
                dst        = 2'd2;
                e.wbSrc    = wbPcPlus8;
                e.regWrite = 2'b11;
            end
        end
        else if (op inside {opBeq, opBne, opBlez, opBgtz, opRegimm})
        begin
            e.delaySlot = 1'b1;
            e.branch    = 1'b1;
            // BLTZAL and BGEZAL link
            if (op == opRegimm && (rt == 5'd16 || rt == 5'd17))
            begin
                dst        = 2'd2;
                e.wbSrc    = wbPcPlus8;
                e.regWrite = 2'b11;
            end
        end
        else
            e.regWrite = 2'b11;

        e.destReg = (dst == 2'd1) ? word[15:11] : ((dst == 2'd2) ? 5'd31 : rt);
        if (e.destReg == 5'd0)
            e.regWrite = 2'b00;
        if (e.jump)
            e.target = {pc4[31:28], word[25:0], 2'b00};
        else if (e.branch)
            e.target = pc4 + offset;
        return e;
    endfunction

    function automatic logic [31:0] encodeRType(input logic [4:0] rs, input logic [4:0] rt,
                                                input logic [4:0] rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeIType(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checkCount++;
        assert (actVal === expVal)
        else
        begin
            $display("ERR %s expected 0x%h actual 0x%h", name, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic compareResult(input expectT e);
        assert (cycleCount - e.issue == pipeLatency)
        else
        begin
            $display("Result arrived %0d cycles after its input instead of %0d",
                     cycleCount - e.issue, pipeLatency);
            errorCount++;
        end
        checkField("regWrite", 32'(e.regWrite), 32'(regWrite));
        checkField("destReg", 32'(e.destReg), 32'(destReg));
        checkField("wbSrc", 32'(e.wbSrc), 32'(wbSrc));
        checkField("memRead", 32'(e.memRead), 32'(memRead));
        checkField("memWrite", 32'(e.memWrite), 32'(memWrite));
        checkField("hiWrite", 32'(e.hiWrite), 32'(hiWrite));
        checkField("loWrite", 32'(e.loWrite), 32'(loWrite));
        checkField("jump", 32'(e.jump), 32'(jump));
        checkField("jumpReg", 32'(e.jumpReg), 32'(jumpReg));
        checkField("delaySlot", 32'(e.delaySlot), 32'(delaySlot));
        checkField("branch", 32'(e.branch), 32'(branch));
        checkField("target", e.target, target);
    endtask

    // Outputs settle after the rising edge, so compare on the falling edge
    always @(negedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (reset === 1'b0 && outValid === 1'b1)
        begin
            assert (expQ.size() != 0)
            else
            begin
                $display("outValid went high with no instruction outstanding");
                errorCount++;
            end
            if (expQ.size() != 0)
                compareResult(expQ.pop_front());
        end
    end

    task automatic checkIdle();
        checkField("outValid", 32'd0, 32'(outValid));
        checkField("regWrite", 32'd0, 32'(regWrite));
        checkField("memRead", 32'd0, 32'(memRead));
        checkField("memWrite", 32'd0, 32'(memWrite));
        checkField("hiWrite", 32'd0, 32'(hiWrite));
        checkField("loWrite", 32'd0, 32'(loWrite));
        checkField("jump", 32'd0, 32'(jump));
        checkField("jumpReg", 32'd0, 32'(jumpReg));
        checkField("delaySlot", 32'd0, 32'(delaySlot));
        checkField("branch", 32'd0, 32'(branch));
    endtask

    task automatic sendInstr(input logic [31:0] word, input logic [31:0] pcVal);
        expectT e;
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= word;
        pc         <= pcVal;
        e          = predictDecode(word, pcVal);
        // Input is seen in the cycle that starts at this edge
        e.issue    = cycleCount + 1;
        expQ.push_back(e);
    endtask

    task automatic sendBubble();
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    task automatic drainPipe();
        sendBubble();
        while (expQ.size() != 0)
            @(posedge clk);
    endtask

    task automatic startTest();
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    task automatic reportTest(input string name);
        $display("Test %-12s %0d checks, %0d errors", name, checkCount - testChecks,
                 errorCount - testErrors);
    endtask

    task automatic runResetTest();
        startTest();
        @(posedge clk);
        @(negedge clk);
        checkIdle();
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkIdle();
        repeat (2)
        begin
            @(negedge clk);
            checkIdle();
        end
        reportTest("reset");
    endtask

    task automatic runRTypeTest();
        functT fnVal;
        startTest();
        fnVal = fnVal.first();
        for (int i = 0; i < fnVal.num(); i++)
        begin
            sendInstr(encodeRType(5'd3, 5'd4, 5'(8 + i), fnVal), 32'h0040_0000 + 32'(4 * i));
            fnVal = fnVal.next();
        end
        foreach (aluFuncts[i])
            sendInstr(encodeRType(5'd5, 5'd6, 5'(20 + i), aluFuncts[i]), 32'h0040_0100);
        // Writes to register zero must be dropped
        sendInstr(encodeRType(5'd3, 5'd4, 5'd0, 6'h20), 32'h0040_0200);
        sendInstr(encodeRType(5'd0, 5'd0, 5'd0, fnMfhi), 32'h0040_0204);
        drainPipe();
        reportTest("rtype");
    endtask

    task automatic runMemTest();
        logic [5:0] memOps [10];
        startTest();
        memOps = '{opLb, opLh, opLwl, opLw, opLbu, opLhu, opLwr, opSb, opSh, opSw};
        foreach (memOps[i])
            sendInstr(encodeIType(memOps[i], 5'd29, 5'(1 + i), 16'(16'h0100 + i)),
                      32'h0040_1000 + 32'(4 * i));
        sendInstr(encodeIType(opLw, 5'd29, 5'd0, 16'hfffc), 32'h0040_1100);
        drainPipe();
        reportTest("loadstore");
    endtask

    task automatic runJumpBranchTest();
        startTest();
        sendInstr({opJ, 26'h0123456}, 32'ha000_0100);
        // pc+4 crosses into the next 256 MB region
        sendInstr({opJ, 26'h3ffffff}, 32'h0fff_fffc);
        sendInstr({opJal, 26'h0000040}, 32'h0040_2000);
        sendInstr(encodeIType(opBeq, 5'd1, 5'd2, 16'h0010), 32'h0040_3000);
        sendInstr(encodeIType(opBne, 5'd1, 5'd2, 16'hfffc), 32'h0040_3004);
        sendInstr(encodeIType(opBlez, 5'd7, 5'd0, 16'h8000), 32'h0040_3008);
        sendInstr(encodeIType(opBgtz, 5'd7, 5'd0, 16'h7fff), 32'h0040_300c);
        sendInstr(encodeIType(opRegimm, 5'd2, 5'd16, 16'hfff8), 32'h0040_3010);
        sendInstr(encodeIType(opRegimm, 5'd2, 5'd17, 16'h0020), 32'h0040_3014);
        sendInstr(encodeIType(opRegimm, 5'd2, 5'd0, 16'hff00), 32'h0000_0010);
        drainPipe();
        reportTest("jumpbranch");
    endtask

    task automatic runThroughputTest();
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] pcVal;
        startTest();
        for (int i = 0; i < randomCount; i++)
        begin
            rnd          = $random(seed);
            word         = $random(seed);
            word[31:26]  = opPool[rnd % opPool.size()];
            if (word[31:26] == opRtype)
            begin
                rnd       = $random(seed);
                word[5:0] = fnPool[rnd % fnPool.size()];
            end
            pcVal      = $random(seed);
            pcVal[1:0] = 2'b00;
            sendInstr(word, pcVal);
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00)
                sendBubble();
        end
        drainPipe();
        reportTest("throughput");
    endtask

    initial
    begin
        #(watchdogNs);
        $display("Timeout: results did not drain within %0d ns", watchdogNs);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        opcodeT opVal;
        functT  fnVal;
        clk        = 1'b0;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;

        // Random pools from the package enums
        opVal = opVal.first();
        for (int i = 0; i < opVal.num(); i++)
        begin
            opPool.push_back(opVal);
            opVal = opVal.next();
        end
        fnVal = fnVal.first();
        for (int i = 0; i < fnVal.num(); i++)
        begin
            fnPool.push_back(fnVal);
            fnVal = fnVal.next();
        end
        foreach (aluFuncts[i])
            fnPool.push_back(aluFuncts[i]);

        runResetTest();
        runRTypeTest();
        runMemTest();
        runJumpBranchTest();
        runThroughputTest();

        $display("Total: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: dv/mipsDecode_checker.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module mipsDecode_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      instrValid,
    input logic                      outValid,
    input logic [1:0]                regWrite,
    input logic [`MIPS_REG_BITS-1:0] destReg,
    input logic                      memRead,
    input logic                      memWrite,
    input logic                      hiWrite,
    input logic                      loWrite,
    input logic                      jump,
    input logic                      jumpReg,
    input logic                      delaySlot,
    input logic                      branch
);

    logic anyControl;

    assign anyControl = (regWrite != 2'b00) | memRead | memWrite | hiWrite | loWrite |
                        jump | jumpReg | delaySlot | branch;

    // Three register stages between instrValid and outValid
    latencyCheck: assert property (@(posedge clk) disable iff (reset)
        outValid == $past(instrValid, 3))
        else $error("outValid does not follow instrValid by three cycles");

    memExclusive: assert property (@(posedge clk) disable iff (reset)
        !(memRead && memWrite))
        else $error("memRead and memWrite are high together");

    zeroDestWrite: assert property (@(posedge clk) disable iff (reset)
        (regWrite != 2'b00) |-> (destReg != '0))
        else $error("register write enabled for register zero");

    idleQuiet: assert property (@(posedge clk) disable iff (reset)
        !outValid |-> !anyControl)
        else $error("control output high while outValid is low");

endmodule

bind mipsDecodePipe mipsDecode_checker i_checker (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .outValid   (outValid),
    .regWrite   (regWrite),
    .destReg    (destReg),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .hiWrite    (hiWrite),
    .loWrite    (loWrite),
    .jump       (jump),
    .jumpReg    (jumpReg),
    .delaySlot  (delaySlot),
    .branch     (branch)
);

// File: hdl/controlUnit.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module controlUnit
    import mipsPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid1,
    input  logic [`MIPS_WORD-1:0] instr1,
    input  logic [`MIPS_WORD-1:0] pc1,
    input  instrClassT            instrClass1,
    output logic                  valid2,
    output logic [`MIPS_WORD-1:0] instr2,
    output logic [`MIPS_WORD-1:0] pc2,
    output logic [1:0]            regWrite2,
    output regDstT                regDst2,
    output wbSrcT                 wbSrc2,
    output logic                  memRead2,
    output logic                  memWrite2,
    output logic                  hiWrite2,
    output logic                  loWrite2,
    output logic                  jump2,
    output logic                  jumpReg2,
    output logic                  delaySlot2
);

    opcodeT                   opcode;
    functT                    funct;
    logic [`MIPS_REG_BITS-1:0] rt;

    logic [1:0] nextRegWrite;
    regDstT     nextRegDst;
    wbSrcT      nextWbSrc;
    logic       nextMemRead;
    logic       nextMemWrite;
    logic       nextHiWrite;
    logic       nextLoWrite;
    logic       nextJump;
    logic       nextJumpReg;
    logic       nextDelaySlot;

    always_comb
    begin
        opcode = opcodeT'(instr1[`MIPS_OPCODE_MSB:`MIPS_OPCODE_LSB]);
        funct  = functT'(instr1[`MIPS_FUNCT]);
        rt     = instr1[`MIPS_RT];

        // Everything off unless a rule below turns it on
        nextRegWrite  = 2'b00;
        nextRegDst    = dstRt;
        nextWbSrc     = wbAlu;
        nextMemRead   = 1'b0;
        nextMemWrite  = 1'b0;
        nextHiWrite   = 1'b0;
        nextLoWrite   = 1'b0;
        nextJump      = 1'b0;
        nextJumpReg   = 1'b0;
        nextDelaySlot = 1'b0;

        case (instrClass1)
            classAlu, classJumpReg:
            begin
                nextRegDst   = dstRd;
                nextRegWrite = 2'b11;
                case (funct)
                    fnJr:
                    begin
                        nextRegWrite  = 2'b00;
                        nextJumpReg   = 1'b1;
                        nextDelaySlot = 1'b1;
                    end
                    fnJalr:
                    begin
                        nextJumpReg   = 1'b1;
                        nextDelaySlot = 1'b1;
                        nextWbSrc     = wbPcPlus8;
                    end
                    fnMfhi:
                        nextWbSrc = wbHi;
                    fnMflo:
                        nextWbSrc = wbLo;
                    fnMthi:
                    begin
                        nextRegWrite = 2'b00;
                        nextHiWrite  = 1'b1;
                    end
                    fnMtlo:
                    begin
                        nextRegWrite = 2'b00;
                        nextLoWrite  = 1'b1;
                    end
                    // Multiply and divide fill both HI and LO
                    fnMult, fnMultu, fnDiv, fnDivu:
                    begin
                        nextRegWrite = 2'b00;
                        nextHiWrite  = 1'b1;
                        nextLoWrite  = 1'b1;
                    end
                    default:
                    begin
                        nextWbSrc = wbAlu;
                    end
                endcase
            end
            classImm:
                nextRegWrite = 2'b11;
            classLoad:
            begin
                nextMemRead = 1'b1;
                nextWbSrc   = wbMem;
                // Unaligned loads only merge part of the word
                case (opcode)
                    opLwl:   nextRegWrite = 2'b01;
                    opLwr:   nextRegWrite = 2'b10;
                    default: nextRegWrite = 2'b11;
                endcase
            end
            classStore:
                nextMemWrite = 1'b1;
            classJump:
            begin
                nextJump      = 1'b1;
                nextDelaySlot = 1'b1;
                if (opcode == opJal)
                begin
                    nextRegDst   = dstLink;
                    nextWbSrc    = wbPcPlus8;
                    nextRegWrite = 2'b11;
                end
            end
            classBranch:
            begin
                nextDelaySlot = 1'b1;
                if (opcode == opRegimm &&
                    (rt == `MIPS_RT_BLTZAL || rt == `MIPS_RT_BGEZAL))
                begin
                    nextRegDst   = dstLink;
                    nextWbSrc    = wbPcPlus8;
                    nextRegWrite = 2'b11;
                end
            end
            default:
            begin
                nextRegWrite = 2'b00;
            end
        endcase
    end

    // Control word drops to zero on a bubble
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid2     <= 1'b0;
            regWrite2  <= 2'b00;
            memRead2   <= 1'b0;
            memWrite2  <= 1'b0;
            hiWrite2   <= 1'b0;
            loWrite2   <= 1'b0;
            jump2      <= 1'b0;
            jumpReg2   <= 1'b0;
            delaySlot2 <= 1'b0;
        end
        else
        begin
            valid2     <= valid1;
            regWrite2  <= valid1 ? nextRegWrite : 2'b00;
            memRead2   <= valid1 & nextMemRead;
            memWrite2  <= valid1 & nextMemWrite;
            hiWrite2   <= valid1 & nextHiWrite;
            loWrite2   <= valid1 & nextLoWrite;
            jump2      <= valid1 & nextJump;
            jumpReg2   <= valid1 & nextJumpReg;
            delaySlot2 <= valid1 & nextDelaySlot;
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid1)
        begin
            instr2  <= instr1;
            pc2     <= pc1;
            regDst2 <= nextRegDst;
            wbSrc2  <= nextWbSrc;
        end
    end

endmodule

// File: hdl/destRouter.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module destRouter
    import mipsPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid2,
    input  logic [`MIPS_WORD-1:0]     instr2,
    input  logic [`MIPS_WORD-1:0]     pc2,
    input  logic [1:0]                regWrite2,
    input  regDstT                    regDst2,
    input  wbSrcT                     wbSrc2,
    input  logic                      memRead2,
    input  logic                      memWrite2,
    input  logic                      hiWrite2,
    input  logic                      loWrite2,
    input  logic                      jump2,
    input  logic                      jumpReg2,
    input  logic                      delaySlot2,
    output logic                      outValid,
    output logic [1:0]                regWrite,
    output logic [`MIPS_REG_BITS-1:0] destReg,
    output wbSrcT                     wbSrc,
    output logic                      memRead,
    output logic                      memWrite,
    output logic                      hiWrite,
    output logic                      loWrite,
    output logic                      jump,
    output logic                      jumpReg,
    output logic                      delaySlot,
    output logic                      branch,
    output logic [`MIPS_WORD-1:0]     target
);

    logic [`MIPS_REG_BITS-1:0] selDest;
    logic [15:0]               imm;
    logic [`MIPS_WORD-1:0]     pcPlus4;
    logic [`MIPS_WORD-1:0]     branchOffset;
    logic [`MIPS_WORD-1:0]     nextTarget;
    logic                      isBranch;

    always_comb
    begin
        case (regDst2)
            dstRd:   selDest = instr2[`MIPS_RD];
            dstLink: selDest = `MIPS_REG_BITS'(`MIPS_LINK_REG);
            default: selDest = instr2[`MIPS_RT];
        endcase
    end

    // Delay slot without a jump of either kind can only be a branch
    assign isBranch     = delaySlot2 & ~jump2 & ~jumpReg2;
    assign imm          = instr2[`MIPS_IMM];
    assign pcPlus4      = pc2 + `MIPS_WORD'(4);
    assign branchOffset = {{(`MIPS_WORD-18){imm[15]}}, imm, 2'b00};

    always_comb
    begin
        if (jump2)
            nextTarget = {pcPlus4[`MIPS_WORD-1:`MIPS_WORD-4], instr2[`MIPS_INDEX], 2'b00};
        else if (isBranch)
            nextTarget = pcPlus4 + branchOffset;
        else
            nextTarget = '0;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outValid  <= 1'b0;
            regWrite  <= 2'b00;
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
            hiWrite   <= 1'b0;
            loWrite   <= 1'b0;
            jump      <= 1'b0;
            jumpReg   <= 1'b0;
            delaySlot <= 1'b0;
            branch    <= 1'b0;
        end
        else
        begin
            outValid  <= valid2;
            // Writes to $zero are dropped here
            regWrite  <= (valid2 && selDest != '0) ? regWrite2 : 2'b00;
            memRead   <= valid2 & memRead2;
            memWrite  <= valid2 & memWrite2;
            hiWrite   <= valid2 & hiWrite2;
            loWrite   <= valid2 & loWrite2;
            jump      <= valid2 & jump2;
            jumpReg   <= valid2 & jumpReg2;
            delaySlot <= valid2 & delaySlot2;
            branch    <= valid2 & isBranch;
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid2)
        begin
            destReg <= selDest;
            wbSrc   <= wbSrc2;
            target  <= nextTarget;
        end
    end

endmodule

// File: hdl/instrClassify.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module instrClassify
    import mipsPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instrValid,
    input  logic [`MIPS_WORD-1:0] instr,
    input  logic [`MIPS_WORD-1:0] pc,
    output logic                  valid1,
    output logic [`MIPS_WORD-1:0] instr1,
    output logic [`MIPS_WORD-1:0] pc1,
    output instrClassT            instrClass1
);

    opcodeT     opcode;
    functT      funct;
    instrClassT nextClass;

    always_comb
    begin
        opcode = opcodeT'(instr[`MIPS_OPCODE_MSB:`MIPS_OPCODE_LSB]);
        funct  = functT'(instr[`MIPS_FUNCT]);
        case (opcode)
            opRtype:
            begin
                // Register jumps get their own class, the rest go to the ALU
                if (funct == fnJr || funct == fnJalr)
                    nextClass = classJumpReg;
                else
                    nextClass = classAlu;
            end
            opJ, opJal:
                nextClass = classJump;
            opBeq, opBne, opBlez, opBgtz, opRegimm:
                nextClass = classBranch;
            opLb, opLh, opLwl, opLw, opLbu, opLhu, opLwr:
                nextClass = classLoad;
            opSb, opSh, opSw:
                nextClass = classStore;
            default:
                nextClass = classImm;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid1 <= 1'b0;
        else
            valid1 <= instrValid;
    end

    // Payload only moves with a valid instruction
    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            instr1      <= instr;
            pc1         <= pc;
            instrClass1 <= nextClass;
        end
    end

endmodule

// File: hdl/mipsDecodePipe.sv
`timescale 1ns/100ps

`include "mips_defs.svh"

module mipsDecodePipe
    import mipsPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instrValid,
    input  logic [`MIPS_WORD-1:0]     instr,
    input  logic [`MIPS_WORD-1:0]     pc,
    output logic                      outValid,
    output logic [1:0]                regWrite,
    output logic [`MIPS_REG_BITS-1:0] destReg,
    output wbSrcT                     wbSrc,
    output logic                      memRead,
    output logic                      memWrite,
    output logic                      hiWrite,
    output logic                      loWrite,
    output logic                      jump,
    output logic                      jumpReg,
    output logic                      delaySlot,
    output logic                      branch,
    output logic [`MIPS_WORD-1:0]     target
);

    // Stage 1 outputs
    logic                  valid1;
    logic [`MIPS_WORD-1:0] instr1;
    logic [`MIPS_WORD-1:0] pc1;
    instrClassT            instrClass1;

    // Stage 2 outputs
    logic                  valid2;
    logic [`MIPS_WORD-1:0] instr2;
    logic [`MIPS_WORD-1:0] pc2;
    logic [1:0]            regWrite2;
    regDstT                regDst2;
    wbSrcT                 wbSrc2;
    logic                  memRead2;
    logic                  memWrite2;
    logic                  hiWrite2;
    logic                  loWrite2;
    logic                  jump2;
    logic                  jumpReg2;
    logic                  delaySlot2;

    instrClassify i_classify (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .valid1      (valid1),
        .instr1      (instr1),
        .pc1         (pc1),
        .instrClass1 (instrClass1)
    );

    controlUnit i_control (
        .clk         (clk),
        .reset       (reset),
        .valid1      (valid1),
        .instr1      (instr1),
        .pc1         (pc1),
        .instrClass1 (instrClass1),
        .valid2      (valid2),
        .instr2      (instr2),
        .pc2         (pc2),
        .regWrite2   (regWrite2),
        .regDst2     (regDst2),
        .wbSrc2      (wbSrc2),
        .memRead2    (memRead2),
        .memWrite2   (memWrite2),
        .hiWrite2    (hiWrite2),
        .loWrite2    (loWrite2),
        .jump2       (jump2),
        .jumpReg2    (jumpReg2),
        .delaySlot2  (delaySlot2)
    );

    destRouter i_router (
        .clk        (clk),
        .reset      (reset),
        .valid2     (valid2),
        .instr2     (instr2),
        .pc2        (pc2),
        .regWrite2  (regWrite2),
        .regDst2    (regDst2),
        .wbSrc2     (wbSrc2),
        .memRead2   (memRead2),
        .memWrite2  (memWrite2),
        .hiWrite2   (hiWrite2),
        .loWrite2   (loWrite2),
        .jump2      (jump2),
        .jumpReg2   (jumpReg2),
        .delaySlot2 (delaySlot2),
        .outValid   (outValid),
        .regWrite   (regWrite),
        .destReg    (destReg),
        .wbSrc      (wbSrc),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .hiWrite    (hiWrite),
        .loWrite    (loWrite),
        .jump       (jump),
        .jumpReg    (jumpReg),
        .delaySlot  (delaySlot),
        .branch     (branch),
        .target     (target)
    );

endmodule

// File: hdl/mipsPkg.sv
package mipsPkg;

    // Primary opcodes handled by the decoder
    typedef enum logic [5:0] {
        opRtype  = 6'h00,
        opRegimm = 6'h01,
        opJ      = 6'h02,
        opJal    = 6'h03,
        opBeq    = 6'h04,
        opBne    = 6'h05,
        opBlez   = 6'h06,
        opBgtz   = 6'h07,
        opAddi   = 6'h08,
        opAddiu  = 6'h09,
        opSlti   = 6'h0a,
        opSltiu  = 6'h0b,
        opAndi   = 6'h0c,
        opOri    = 6'h0d,
        opXori   = 6'h0e,
        opLui    = 6'h0f,
        opLb     = 6'h20,
        opLh     = 6'h21,
        opLwl    = 6'h22,
        opLw     = 6'h23,
        opLbu    = 6'h24,
        opLhu    = 6'h25,
        opLwr    = 6'h26,
        opSb     = 6'h28,
        opSh     = 6'h29,
        opSw     = 6'h2b
    } opcodeT;

    // R-type functs that need more than a plain ALU write
    typedef enum logic [5:0] {
        fnJr    = 6'h08,
        fnJalr  = 6'h09,
        fnMfhi  = 6'h10,
        fnMthi  = 6'h11,
        fnMflo  = 6'h12,
        fnMtlo  = 6'h13,
        fnMult  = 6'h18,
        fnMultu = 6'h19,
        fnDiv   = 6'h1a,
        fnDivu  = 6'h1b
    } functT;

    typedef enum logic [2:0] {
        classAlu,
        classImm,
        classLoad,
        classStore,
        classBranch,
        classJump,
        classJumpReg
    } instrClassT;

    typedef enum logic [1:0] {
        dstRt   = 2'd0,
        dstRd   = 2'd1,
        dstLink = 2'd2
    } regDstT;

    typedef enum logic [2:0] {
        wbAlu     = 3'd0,
        wbMem     = 3'd1,
        wbPcPlus8 = 3'd2,
        wbHi      = 3'd3,
        wbLo      = 3'd4
    } wbSrcT;

endpackage

// File: hdl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath widths
`define MIPS_WORD       32
`define MIPS_REG_BITS   5

// Link register for JAL, BLTZAL and BGEZAL
`define MIPS_LINK_REG   31

// Instruction field positions
`define MIPS_OPCODE_MSB 31
`define MIPS_OPCODE_LSB 26
`define MIPS_RS         25:21
`define MIPS_RT         20:16
`define MIPS_RD         15:11
`define MIPS_FUNCT      5:0
`define MIPS_IMM        15:0
`define MIPS_INDEX      25:0

// REGIMM rt codes that also link
`define MIPS_RT_BLTZAL  16
`define MIPS_RT_BGEZAL  17

`endif

// File: mipsDecode.f
+incdir+hdl
hdl/mipsPkg.sv
hdl/instrClassify.sv
hdl/controlUnit.sv
hdl/destRouter.sv
hdl/mipsDecodePipe.sv
dv/mipsDecode_checker.sv
dv/mipsDecodeTb.sv
